/* Makefile */
VERILATOR ?= verilator
TOP       ?= cgra_tile_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= test failed
PASS_MSG  ?= test passed

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "FAIL: no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/cgra_tile_tb.sv */
module cgra_tile_tb import cgra_pkg::*; ();

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 3;
	localparam int APB_CYCLES   = 3; // setup, access, idle
	localparam int HOLD_CYCLES  = 4;
	localparam int SB_ITERS     = 50;
	localparam int PE_ITERS     = 30;
	localparam int REG_ITERS    = 20;
	localparam int ITER_CYCLES  = APB_CYCLES + HOLD_CYCLES;
	localparam int RUN_CYCLES   = RESET_CYCLES + 10 + 14 * APB_CYCLES + HOLD_CYCLES
		+ (SB_ITERS + PE_ITERS + REG_ITERS) * ITER_CYCLES;
	localparam int TIMEOUT_CYCLES = 2 * RUN_CYCLES;

	logic                  clk;
	logic                  reset;
	logic                  psel;
	logic                  penable;
	logic                  pwrite;
	logic [APB_ADDR_W-1:0] paddr;
	logic [CFG_W-1:0]      pwdata;
	logic [CFG_W-1:0]      prdata;
	logic                  pready;
	logic                  pslverr;
	logic [NUM_TRACKS-1:0] north_in;
	logic [NUM_TRACKS-1:0] west_in;
	logic [NUM_TRACKS-1:0] north_out;
	logic [NUM_TRACKS-1:0] west_out;

	logic [CFG_W-1:0] sb_model;
	logic [CFG_W-1:0] pe_model;
	logic             prev_lut; // lookup result latched at the last edge
	logic [31:0]      lcg_state;
	logic             check_en;
	int               err_cnt;
	int               test_start_errs;
	int               tests_run;
	int               tests_clean;
	int               cycle_cnt;

	cgra_tile_bl dut (
		.clk         (clk),
		.reset       (reset),
		.psel_i      (psel),
		.penable_i   (penable),
		.pwrite_i    (pwrite),
		.paddr_i     (paddr),
		.pwdata_i    (pwdata),
		.prdata_o    (prdata),
		.pready_o    (pready),
		.pslverr_o   (pslverr),
		.north_in_i  (north_in),
		.west_in_i   (west_in),
		.north_out_o (north_out),
		.west_out_o  (west_out)
	);

	initial begin : clock_gen
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic pe_lookup(input logic [CFG_W-1:0] word,
			input logic [NUM_TRACKS-1:0] nin, input logic [NUM_TRACKS-1:0] win);
		logic [2:0] sa;
		logic [2:0] sb;
		logic [1:0] idx;
		sa  = word[2:0];
		sb  = word[5:3];
		// bit 2 of a select picks the west side
		idx = {sb[2] ? win[sb[1:0]] : nin[sb[1:0]], sa[2] ? win[sa[1:0]] : nin[sa[1:0]]};
		return word[6 + idx]; // lut bit 2b+a
	endfunction

	function automatic logic [2*NUM_TRACKS-1:0] expected_tracks(input logic [CFG_W-1:0] sbw,
			input logic pe_bit, input logic [NUM_TRACKS-1:0] nin, input logic [NUM_TRACKS-1:0] win);
		logic [NUM_TRACKS-1:0] w_rot;
		logic [NUM_TRACKS-1:0] n_rot;
		logic [NUM_TRACKS-1:0] n_exp;
		logic [NUM_TRACKS-1:0] w_exp;
		w_rot = {win[1:0], win[3:2]}; // w_rot[k] = win[(k+2) mod 4]
		n_rot = {nin[2:0], nin[3]};   // n_rot[k] = nin[(k+3) mod 4]
		for (int k = 0; k < NUM_TRACKS; k++) begin
			case (sbw[2*k +: 2])
				2'd2:    n_exp[k] = w_rot[k];
				2'd3:    n_exp[k] = pe_bit;
				default: n_exp[k] = 1'b0;
			endcase
			case (sbw[24 + 2*k +: 2])
				2'd0:    w_exp[k] = n_rot[k];
				2'd3:    w_exp[k] = pe_bit;
				default: w_exp[k] = 1'b0;
			endcase
		end
		return {w_exp, n_exp};
	endfunction

	task automatic expect_bits(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			err_cnt++;
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	always @(posedge clk) begin
		if (reset)
			prev_lut <= 1'b0;
		else
			prev_lut <= pe_lookup(pe_model, north_in, west_in);
	end

	// compares in the last step before each rising edge, inputs already moved on
	always begin
		logic                    pe_bit;
		logic [2*NUM_TRACKS-1:0] exp;
		@(negedge clk);
		#(CLK_PERIOD / 2 - 1);
		if (check_en) begin
			pe_bit = pe_model[PE_REG_BIT] ? prev_lut : pe_lookup(pe_model, north_in, west_in);
			exp    = expected_tracks(sb_model, pe_bit, north_in, west_in);
			expect_bits("north_out", 32'(north_out), 32'(exp[3:0]));
			expect_bits("west_out", 32'(west_out), 32'(exp[7:4]));
			expect_bits("pready", 32'(pready), 32'd1);
			if (!(psel && penable)) begin
				expect_bits("idle prdata", prdata, 32'd0);
				expect_bits("idle pslverr", 32'(pslverr), 32'd0);
			end
		end
	end

	task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [CFG_W-1:0] data);
		logic exp_err;
		exp_err = !(addr == ADDR_SB_CFG || addr == ADDR_PE_CFG);
		@(negedge clk);
		psel    = 1'b1;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(negedge clk);
		penable = 1'b1;
		@(posedge clk);
		expect_bits("write pslverr", 32'(pslverr), 32'(exp_err));
		#1; // model follows the edge that loads the word
		if (addr == ADDR_SB_CFG)
			sb_model = data;
		else if (addr == ADDR_PE_CFG)
			pe_model = data;
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [CFG_W-1:0] data,
			output logic err);
		@(negedge clk);
		psel    = 1'b1;
		pwrite  = 1'b0;
		paddr   = addr;
		@(negedge clk);
		penable = 1'b1;
		@(posedge clk);
		data = prdata;
		err  = pslverr;
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic drive_tracks(input int cycles);
		logic [31:0] r;
		repeat (cycles) begin
			@(negedge clk);
			r        = next_rand();
			north_in = r[31:28]; // upper lcg bits
			west_in  = r[27:24];
		end
	endtask

	task automatic end_test(input string name);
		int errs;
		errs = err_cnt - test_start_errs;
		tests_run++;
		if (errs == 0) begin
			tests_clean++;
			$display("%-12s ok", name);
		end else
			$display("%-12s %0d errors", name, errs);
		test_start_errs = err_cnt;
	endtask

	initial begin : main
		logic [CFG_W-1:0] sb_word;
		logic [CFG_W-1:0] pe_word;
		logic [CFG_W-1:0] rd;
		logic             rd_err;
		lcg_state       = 32'he396_8bf4;
		reset           = 1'b1;
		psel            = 1'b0;
		penable         = 1'b0;
		pwrite          = 1'b0;
		paddr           = '0;
		pwdata          = '0;
		north_in        = '0;
		west_in         = '0;
		sb_model        = '0;
		pe_model        = '0;
		check_en        = 1'b0;
		err_cnt         = 0;
		test_start_errs = 0;
		tests_run       = 0;
		tests_clean     = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset    = 1'b0;
		check_en = 1'b1;

		drive_tracks(10);
		end_test("reset_state");

		apb_write(ADDR_PE_CFG, next_rand() & ~(32'h1 << PE_REG_BIT));
		for (int i = 0; i < SB_ITERS; i++) begin
			apb_write(ADDR_SB_CFG, next_rand());
			drive_tracks(HOLD_CYCLES);
		end
		end_test("sb_routing");

		apb_write(ADDR_SB_CFG, 32'h0000_00ff); // every north track from the pe
		for (int i = 0; i < PE_ITERS; i++) begin
			apb_write(ADDR_PE_CFG, next_rand() & ~(32'h1 << PE_REG_BIT));
			drive_tracks(HOLD_CYCLES);
		end
		end_test("pe_comb");

		for (int i = 0; i < REG_ITERS; i++) begin
			apb_write(ADDR_PE_CFG, next_rand() | (32'h1 << PE_REG_BIT));
			drive_tracks(HOLD_CYCLES);
		end
		end_test("pe_reg");

		sb_word = next_rand();
		pe_word = next_rand();
		apb_write(ADDR_SB_CFG, sb_word);
		apb_write(ADDR_PE_CFG, pe_word);
		apb_read(ADDR_SB_CFG, rd, rd_err);
		expect_bits("sb readback", rd, sb_word);
		expect_bits("sb read pslverr", 32'(rd_err), 32'd0);
		apb_read(ADDR_PE_CFG, rd, rd_err);
		expect_bits("pe readback", rd, pe_word);
		expect_bits("pe read pslverr", 32'(rd_err), 32'd0);
		apb_read(ADDR_ID, rd, rd_err);
		expect_bits("tile id", rd, TILE_ID);
		expect_bits("id read pslverr", 32'(rd_err), 32'd0);
		apb_read(4'hc, rd, rd_err);
		expect_bits("unmapped read pslverr", 32'(rd_err), 32'd1);
		apb_read(4'h2, rd, rd_err);
		expect_bits("unmapped read pslverr", 32'(rd_err), 32'd1);
		apb_write(ADDR_ID, next_rand()); // rejected, model unchanged
		apb_write(4'hc, next_rand());
		drive_tracks(HOLD_CYCLES);
		apb_read(ADDR_SB_CFG, rd, rd_err);
		expect_bits("sb after errors", rd, sb_word);
		apb_read(ADDR_PE_CFG, rd, rd_err);
		expect_bits("pe after errors", rd, pe_word);
		end_test("apb_regs");

		check_en = 1'b0;
		$display("summary: %0d tests run, %0d without errors, %0d errors in total",
			tests_run, tests_clean, err_cnt);
		if (err_cnt == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	initial begin : watchdog
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("test failed");
		$finish;
	end

endmodule

/* files.f */
hw/cgra_pkg.sv
hw/cgra_cfg_apb.sv
hw/switch_box_bottom_left.sv
hw/cgra_pe.sv
hw/cgra_tile_bl.sv
dv/cgra_tile_tb.sv

/* hw/cgra_cfg_apb.sv */
module cgra_cfg_apb import cgra_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  psel_i,
	input  logic                  penable_i,
	input  logic                  pwrite_i,
	input  logic [APB_ADDR_W-1:0] paddr_i,
	input  logic [CFG_W-1:0]      pwdata_i,
	input  logic [CFG_W-1:0]      sb_cfg_q_i,
	input  logic [CFG_W-1:0]      pe_cfg_q_i,
	output logic [CFG_W-1:0]      prdata_o,
	output logic                  pready_o,
	output logic                  pslverr_o,
	output logic [CFG_W-1:0]      cfg_data_o,
	output logic                  sb_cfg_en_o,
	output logic                  pe_cfg_en_o
);

	logic access;
	logic hit_sb;
	logic hit_pe;
	logic hit_id;
	logic addr_err;
	logic psel_q;

	assign access = psel_i & penable_i;

	assign hit_sb = (paddr_i == ADDR_SB_CFG);
	assign hit_pe = (paddr_i == ADDR_PE_CFG);
	assign hit_id = (paddr_i == ADDR_ID);

	// id is read only, anything else unmapped
	assign addr_err = !(hit_sb || hit_pe || hit_id) || (pwrite_i && hit_id);

	// strobes fire on the access cycle, so the word lands at the edge ending it
	assign sb_cfg_en_o = access & pwrite_i & hit_sb;
	assign pe_cfg_en_o = access & pwrite_i & hit_pe;
	assign cfg_data_o  = pwdata_i;

	assign pready_o  = 1'b1; // no wait states
	assign pslverr_o = access & addr_err;

	always_comb begin
		prdata_o = '0;
		if (access && !pwrite_i) begin
			if (hit_sb)
				prdata_o = sb_cfg_q_i;
			else if (hit_pe)
				prdata_o = pe_cfg_q_i;
			else if (hit_id)
				prdata_o = TILE_ID;
		end
	end

	// remembers psel for the protocol check
	always_ff @(posedge clk) begin
		if (reset)
			psel_q <= 1'b0;
		else
			psel_q <= psel_i;
	end

	// access phase must follow a cycle with psel high
	a_penable_after_psel: assert property (
		@(posedge clk) disable iff (reset)
		penable_i |-> psel_q
	) else $error("penable without preceding psel");

endmodule

/* hw/cgra_pe.sv */
module cgra_pe import cgra_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [NUM_TRACKS-1:0] north_in_i,
	input  logic [NUM_TRACKS-1:0] west_in_i,
	input  logic [CFG_W-1:0]      cfg_data_i,
	input  logic                  cfg_en_i,
	output logic                  pe_out_o,
	output logic [CFG_W-1:0]      cfg_q_o
);

	logic [CFG_W-1:0]        cfg_word;
	logic [2*NUM_TRACKS-1:0] tile_in;
	logic [PE_SEL_W-1:0]     sel_a;
	logic [PE_SEL_W-1:0]     sel_b;
	logic [PE_LUT_W-1:0]     lut;
	logic                    reg_mode;
	logic                    in_a;
	logic                    in_b;
	logic                    lut_res;
	logic                    res_q;

	always_ff @(posedge clk) begin
		if (reset)
			cfg_word <= '0;
		else if (cfg_en_i)
			cfg_word <= cfg_data_i;
	end

	assign cfg_q_o = cfg_word;

	assign sel_a    = cfg_word[PE_SEL_A_LSB +: PE_SEL_W];
	assign sel_b    = cfg_word[PE_SEL_B_LSB +: PE_SEL_W];
	assign lut      = cfg_word[PE_LUT_LSB +: PE_LUT_W];
	assign reg_mode = cfg_word[PE_REG_BIT];

	// selects 0-3 north, 4-7 west
	assign tile_in = {west_in_i, north_in_i};
	assign in_a    = tile_in[sel_a];
	assign in_b    = tile_in[sel_b];

	assign lut_res = lut[{in_b, in_a}]; // index 2b+a

	// flop runs every cycle, mode only picks the tap
	always_ff @(posedge clk) begin
		if (reset)
			res_q <= 1'b0;
		else
			res_q <= lut_res;
	end

	assign pe_out_o = reg_mode ? res_q : lut_res;

	// select bit 2 picks the west side
	a_reg_mode_delay: assert property (
		@(posedge clk) disable iff (reset)
		reg_mode && !$past(reset) |-> pe_out_o == $past(lut[{
			sel_b[2] ? west_in_i[sel_b[1:0]] : north_in_i[sel_b[1:0]],
			sel_a[2] ? west_in_i[sel_a[1:0]] : north_in_i[sel_a[1:0]]}])
	) else $error("registered pe output does not match last lookup");

endmodule

/* hw/cgra_pkg.sv */
package cgra_pkg;

	// config word and track widths
	localparam int CFG_W      = 32;
	localparam int NUM_TRACKS = 4;

	// apb address map
	localparam int APB_ADDR_W = 4;
	localparam logic [APB_ADDR_W-1:0] ADDR_SB_CFG = 4'h0;
	localparam logic [APB_ADDR_W-1:0] ADDR_PE_CFG = 4'h4;
	localparam logic [APB_ADDR_W-1:0] ADDR_ID     = 4'h8; // read only

	// bottom-left tile variant
	localparam logic [CFG_W-1:0] TILE_ID = 32'hc6a0_0b13;

	// pe word fields
	localparam int PE_SEL_W     = 3;
	localparam int PE_SEL_A_LSB = 0;
	localparam int PE_SEL_B_LSB = 3;
	localparam int PE_LUT_LSB   = 6;
	localparam int PE_LUT_W     = 4;
	localparam int PE_REG_BIT   = 10;

	// sb word fields, two bits per output
	localparam int SB_FIELD_W    = 2;
	localparam int SB_NORTH_LSB  = 0;
	localparam int SB_WEST_LSB   = 24;

	// sb field codes
	localparam logic [SB_FIELD_W-1:0] SB_N_FROM_WEST = 2'd2;
	localparam logic [SB_FIELD_W-1:0] SB_W_FROM_NORTH = 2'd0;
	localparam logic [SB_FIELD_W-1:0] SB_FROM_PE     = 2'd3;

endpackage

/* hw/cgra_tile_bl.sv */
module cgra_tile_bl import cgra_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  psel_i,
	input  logic                  penable_i,
	input  logic                  pwrite_i,
	input  logic [APB_ADDR_W-1:0] paddr_i,
	input  logic [CFG_W-1:0]      pwdata_i,
	output logic [CFG_W-1:0]      prdata_o,
	output logic                  pready_o,
	output logic                  pslverr_o,
	input  logic [NUM_TRACKS-1:0] north_in_i,
	input  logic [NUM_TRACKS-1:0] west_in_i,
	output logic [NUM_TRACKS-1:0] north_out_o,
	output logic [NUM_TRACKS-1:0] west_out_o
);

	logic [CFG_W-1:0] cfg_data;
	logic [CFG_W-1:0] sb_cfg_q;
	logic [CFG_W-1:0] pe_cfg_q;
	logic             sb_cfg_en;
	logic             pe_cfg_en;
	logic             pe_out;

	cgra_cfg_apb u_cfg (
		.clk         (clk),
		.reset       (reset),
		.psel_i      (psel_i),
		.penable_i   (penable_i),
		.pwrite_i    (pwrite_i),
		.paddr_i     (paddr_i),
		.pwdata_i    (pwdata_i),
		.sb_cfg_q_i  (sb_cfg_q),
		.pe_cfg_q_i  (pe_cfg_q),
		.prdata_o    (prdata_o),
		.pready_o    (pready_o),
		.pslverr_o   (pslverr_o),
		.cfg_data_o  (cfg_data),
		.sb_cfg_en_o (sb_cfg_en),
		.pe_cfg_en_o (pe_cfg_en)
	);

	switch_box_bottom_left u_sb (
		.clk         (clk),
		.reset       (reset),
		.north_in_i  (north_in_i),
		.west_in_i   (west_in_i),
		.pe_out_i    (pe_out),
		.cfg_data_i  (cfg_data),
		.cfg_en_i    (sb_cfg_en),
		.north_out_o (north_out_o),
		.west_out_o  (west_out_o),
		.cfg_q_o     (sb_cfg_q)
	);

	// pe taps the raw track inputs, no connection box
	cgra_pe u_pe (
		.clk        (clk),
		.reset      (reset),
		.north_in_i (north_in_i),
		.west_in_i  (west_in_i),
		.cfg_data_i (cfg_data),
		.cfg_en_i   (pe_cfg_en),
		.pe_out_o   (pe_out),
		.cfg_q_o    (pe_cfg_q)
	);

endmodule

/* hw/switch_box_bottom_left.sv */
module switch_box_bottom_left import cgra_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [NUM_TRACKS-1:0] north_in_i,
	input  logic [NUM_TRACKS-1:0] west_in_i,
	input  logic                  pe_out_i,
	input  logic [CFG_W-1:0]      cfg_data_i,
	input  logic                  cfg_en_i,
	output logic [NUM_TRACKS-1:0] north_out_o,
	output logic [NUM_TRACKS-1:0] west_out_o,
	output logic [CFG_W-1:0]      cfg_q_o
);

	logic [CFG_W-1:0] cfg_word;

	// whole word kept, bits 23:8 only for readback
	always_ff @(posedge clk) begin
		if (reset)
			cfg_word <= '0;
		else if (cfg_en_i)
			cfg_word <= cfg_data_i;
	end

	assign cfg_q_o = cfg_word;

	// north side outputs
	for (genvar k = 0; k < NUM_TRACKS; k++) begin : g_north
		logic [SB_FIELD_W-1:0] sel;

		assign sel = cfg_word[SB_NORTH_LSB + SB_FIELD_W*k +: SB_FIELD_W];

		always_comb begin
			case (sel)
				SB_N_FROM_WEST: north_out_o[k] = west_in_i[(k+2) % NUM_TRACKS];
				SB_FROM_PE:     north_out_o[k] = pe_out_i;
				default:        north_out_o[k] = 1'b0;
			endcase
		end
	end

	// west side outputs, code 0 passes north through
	for (genvar k = 0; k < NUM_TRACKS; k++) begin : g_west
		logic [SB_FIELD_W-1:0] sel;

		assign sel = cfg_word[SB_WEST_LSB + SB_FIELD_W*k +: SB_FIELD_W];

		always_comb begin
			case (sel)
				SB_W_FROM_NORTH: west_out_o[k] = north_in_i[(k+3) % NUM_TRACKS];
				SB_FROM_PE:      west_out_o[k] = pe_out_i;
				default:         west_out_o[k] = 1'b0;
			endcase
		end
	end

	a_cfg_known: assert property (
		@(posedge clk) disable iff (reset)
		!$isunknown(cfg_word)
	) else $error("switch box config word unknown");

endmodule
